// File: sources.f
source/lc4_pkg.sv
source/lc4_decoder.sv
source/lc4_regfile.sv
source/lc4_issue_ctrl.sv
source/lc4_exec_lane.sv
source/lc4_dmem_arbiter.sv
source/lc4_superscalar.sv
tb/lc4_superscalar_assertions.sv
tb/lc4_retire_checker.sv
tb/lc4_superscalar_tb.sv

// File: Bender.yml
package:
  name: lc4_superscalar

sources:
  - source/lc4_pkg.sv
  - source/lc4_decoder.sv
  - source/lc4_regfile.sv
  - source/lc4_issue_ctrl.sv
  - source/lc4_exec_lane.sv
  - source/lc4_dmem_arbiter.sv
  - source/lc4_superscalar.sv
  - target: test
    files:
      - tb/lc4_superscalar_assertions.sv
      - tb/lc4_retire_checker.sv
      - tb/lc4_superscalar_tb.sv

// File: tb/lc4_program_patterns.hex
// one 16-bit instruction word per line, loaded at p_reset_pc upward
// the comment after each word names the instruction
9205 // const r1, #5
9403 // const r2, #3
1642 // add r3, r1, r2
18D1 // sub r4, r3, r1
1B3E // addi r5, r4, #-2
5D42 // and r6, r5, r2
9FF0 // const r7, #-16
1242 // add r1, r1, r2
65C0 // ldr r2, r7, #0
1681 // add r3, r2, r1
9840 // const r4, #0x40
1AE1 // addi r5, r3, #1
7B02 // str r5, r4, #2
7303 // str r1, r4, #3
6D02 // ldr r6, r4, #2
6F05 // ldr r7, r4, #5
1387 // add r1, r6, r7
733F // str r1, r4, #-1
5441 // and r2, r1, r1
673F // ldr r3, r4, #-1
10C3 // add r0, r3, r3
1027 // addi r0, r0, #7
C1C0 // jmp, decodes as nop
0000 // nop

// File: tb/lc4_superscalar_tb.sv
`default_nettype none

module lc4_superscalar_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam lc4_pkg::word_t reset_pc = 16'h8200;

    logic               gwe;
    logic               i_rst_n;
    lc4_pkg::word_t     o_pc;
    lc4_pkg::word_t     i_insn_a;
    lc4_pkg::word_t     i_insn_b;
    lc4_pkg::word_t     o_dmem_addr;
    logic               o_dmem_we;
    lc4_pkg::word_t     o_dmem_wdata;
    lc4_pkg::word_t     i_dmem_rdata;
    lc4_pkg::wb_trace_t o_wb_a;
    lc4_pkg::wb_trace_t o_wb_b;
    logic               done;
    int                 chk_errors;
    int                 retired;
    int                 dual;
    int                 tb_errors;
    int                 assert_errors;
    int                 cycles;
    int                 limit;
    int                 prog_len;
    logic [15:0]        imem [256];
    logic [15:0]        dmem [65536];

    lc4_superscalar #(
        .p_reset_pc (reset_pc)
    ) lc4_superscalar_i (
        .gwe          (gwe),
        .i_rst_n      (i_rst_n),
        .o_pc         (o_pc),
        .i_insn_a     (i_insn_a),
        .i_insn_b     (i_insn_b),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_we    (o_dmem_we),
        .o_dmem_wdata (o_dmem_wdata),
        .i_dmem_rdata (i_dmem_rdata),
        .o_wb_a       (o_wb_a),
        .o_wb_b       (o_wb_b)
    );

    lc4_retire_checker #(
        .p_reset_pc (reset_pc)
    ) u_checker (
        .gwe          (gwe),
        .i_rst_n      (i_rst_n),
        .i_wb_a       (o_wb_a),
        .i_wb_b       (o_wb_b),
        .i_dmem_we    (o_dmem_we),
        .i_dmem_addr  (o_dmem_addr),
        .i_dmem_wdata (o_dmem_wdata),
        .o_done       (done),
        .o_errors     (chk_errors),
        .o_retired    (retired),
        .o_dual       (dual)
    );

    always #20 gwe = ~gwe;

    // words past the program, or an unknown pc, read as nop
    function automatic logic [15:0] imem_word(logic [15:0] pc);
        logic [15:0] idx;
        idx = pc - reset_pc;
        if ($isunknown(pc) || int'(idx) >= prog_len) return 16'h0000;
        return imem[idx];
    endfunction

    always @(negedge gwe) begin
        if (i_rst_n && o_dmem_we === 1'b1) begin
            dmem[o_dmem_addr] = o_dmem_wdata;
        end
        i_insn_a     = imem_word(o_pc);
        i_insn_b     = imem_word(o_pc + 16'd1);
        i_dmem_rdata = $isunknown(o_dmem_addr) ? 16'h0000 : dmem[o_dmem_addr];
    end

    initial begin
        gwe           = 1'b0;
        i_rst_n       = 1'b0;
        i_insn_a      = '0;
        i_insn_b      = '0;
        i_dmem_rdata  = '0;
        tb_errors     = 0;
        assert_errors = 0;
        cycles        = 0;
        $readmemh("tb/lc4_program_patterns.hex", imem);
        prog_len = 0;
        while (prog_len < 256 && !$isunknown(imem[prog_len])) begin
            prog_len++;
        end
        for (int i = 0; i < 65536; i++) begin
            dmem[i] = 16'(i) ^ 16'h5a5a;
        end
        limit = 4 * prog_len + 20;
        repeat (3) @(negedge gwe);
        i_rst_n = 1'b1;
        // the checker updates on the falling edge, so it is read on the rising one
        while (!done && cycles < limit) begin
            @(posedge gwe);
            cycles++;
        end
        #1;
        assert_errors = lc4_superscalar_i.u_assertions.fail_count;
        if (!done) begin
            $display("timeout after %0d cycles with only %0d of %0d instructions retired",
                     cycles, retired, prog_len);
            tb_errors++;
        end
        if (dual == 0) begin
            $display("no cycle retired both lanes together");
            tb_errors++;
        end
        $display("retired %0d, dual %0d, checker errors %0d, assertion errors %0d, tb errors %0d",
                 retired, dual, chk_errors, assert_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0 && assert_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/lc4_retire_checker.sv
`default_nettype none

module lc4_retire_checker #(
    parameter lc4_pkg::word_t p_reset_pc = 16'h8200
) (
    input  wire                     gwe,
    input  wire                     i_rst_n,
    input  wire lc4_pkg::wb_trace_t i_wb_a,
    input  wire lc4_pkg::wb_trace_t i_wb_b,
    input  wire                     i_dmem_we,
    input  wire lc4_pkg::word_t     i_dmem_addr,
    input  wire lc4_pkg::word_t     i_dmem_wdata,
    output logic                    o_done,
    output int                      o_errors,
    output int                      o_retired,
    output int                      o_dual
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [15:0] prog [256];
    logic [15:0] regs [8];
    logic [15:0] mem [65536];
    logic [15:0] exp_pc;
    logic [15:0] st_addr_q [$];
    logic [15:0] st_data_q [$];
    int          prog_len;

    initial begin
        $readmemh("tb/lc4_program_patterns.hex", prog);
        prog_len = 0;
        while (prog_len < 256 && !$isunknown(prog[prog_len])) begin
            prog_len++;
        end
        for (int i = 0; i < 8; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 16'(i) ^ 16'h5a5a;
        end
        exp_pc    = p_reset_pc;
        o_done    = 1'b0;
        o_errors  = 0;
        o_retired = 0;
        o_dual    = 0;
    end

    function automatic logic [15:0] fetch(logic [15:0] pc);
        logic [15:0] idx;
        idx = pc - p_reset_pc;
        return (int'(idx) < prog_len) ? prog[idx] : 16'h0000;
    endfunction

    function automatic logic [15:0] sext(logic [15:0] v, int bits);
        logic [15:0] upper;
        upper = 16'hffff << bits;
        return v[bits-1] ? (v | upper) : (v & ~upper);
    endfunction

    task automatic check_word(string name, logic [15:0] expected, logic [15:0] got);
        if (expected !== got) begin
            $display("FAIL %s expected %h got %h", name, expected, got);
            o_errors++;
        end
    endtask

    // steps the model by one instruction and compares the trace
    task automatic retire(lc4_pkg::wb_trace_t wb, string lane);
        logic [15:0] insn;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] res;
        logic [15:0] addr;
        logic        we;
        logic        is_store;
        insn     = fetch(exp_pc);
        check_word({lane, ".pc"}, exp_pc, wb.pc);
        check_word({lane, ".insn"}, insn, wb.insn);
        a        = regs[insn[8:6]];
        b        = regs[insn[2:0]];
        we       = 1'b0;
        is_store = 1'b0;
        res      = '0;
        addr     = a + sext(insn, 6);
        case (insn[15:12])
            4'h1: begin
                we = insn[5] || insn[5:3] == 3'b000 || insn[5:3] == 3'b010;
                if (insn[5]) res = a + sext(insn, 5);
                else if (insn[5:3] == 3'b000) res = a + b;
                else res = a - b;
            end
            4'h5: begin
                we  = (insn[5:3] == 3'b000);
                res = a & b;
            end
            4'h6: begin
                we  = 1'b1;
                res = mem[addr];
            end
            4'h7: begin
                is_store = 1'b1;
                res      = regs[insn[11:9]];
            end
            4'h9: begin
                we  = 1'b1;
                res = sext(insn, 9);
            end
            default: we = 1'b0;
        endcase
        check_word({lane, ".we"}, {15'b0, we}, {15'b0, wb.we});
        if (we) begin
            check_word({lane, ".wsel"}, {13'b0, insn[11:9]}, {13'b0, wb.wsel});
            check_word({lane, ".wdata"}, res, wb.wdata);
            regs[insn[11:9]] = res;
        end
        if (is_store) begin
            if (st_addr_q.size() == 0) begin
                $display("store at pc %h retired without a data memory write", exp_pc);
                o_errors++;
            end else begin
                check_word("o_dmem_addr", addr, st_addr_q.pop_front());
                check_word("o_dmem_wdata", res, st_data_q.pop_front());
            end
            mem[addr] = res;
        end
        exp_pc = exp_pc + 16'd1;
        o_retired++;
    endtask

    always @(negedge gwe) begin
        if (i_rst_n) begin
            // a store is written in M and retires one cycle later
            if (i_dmem_we) begin
                st_addr_q.push_back(i_dmem_addr);
                st_data_q.push_back(i_dmem_wdata);
            end
            if (i_wb_b.valid && !i_wb_a.valid) begin
                $display("lane b retired pc %h while lane a retired nothing", i_wb_b.pc);
                o_errors++;
            end
            if (i_wb_a.valid) retire(i_wb_a, "o_wb_a");
            if (i_wb_b.valid) retire(i_wb_b, "o_wb_b");
            if (i_wb_a.valid && i_wb_b.valid) o_dual++;
            // only the write of this cycle may still wait for its store
            if (st_addr_q.size() > (i_dmem_we ? 1 : 0)) begin
                $display("data memory written at %h with no store retiring after it",
                         st_addr_q[0]);
                o_errors++;
                void'(st_addr_q.pop_front());
                void'(st_data_q.pop_front());
            end
            if (int'(16'(exp_pc - p_reset_pc)) >= prog_len) o_done = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: tb/lc4_superscalar_assertions.sv
`default_nettype none

module lc4_superscalar_assertions (
    input wire                    gwe,
    input wire                    i_rst_n,
    input wire lc4_pkg::mem_req_t i_req_a,
    input wire lc4_pkg::mem_req_t i_req_b,
    input wire                    i_dmem_we,
    input wire lc4_pkg::wb_trace_t i_wb_a,
    input wire lc4_pkg::wb_trace_t i_wb_b
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // two memory ops of one pair are split, so a store never shares M with another request
    we_in_mem_pair: assert property (@(posedge gwe) disable iff (!i_rst_n)
        !(i_dmem_we && (i_req_a.load || i_req_a.store) && (i_req_b.load || i_req_b.store)))
        else begin
            $error("data port written while both lanes hold a memory request in M");
            fail_count++;
        end

    b_needs_a: assert property (@(posedge gwe) disable iff (!i_rst_n)
        !(i_wb_b.valid && !i_wb_a.valid))
        else begin
            $error("lane b retired without lane a");
            fail_count++;
        end

    wb_idle_in_reset: assert property (@(posedge gwe)
        !i_rst_n |=> (!i_wb_a.valid && !i_wb_b.valid))
        else begin
            $error("retirement seen during reset");
            fail_count++;
        end

endmodule

bind lc4_superscalar lc4_superscalar_assertions u_assertions (
    .gwe       (gwe),
    .i_rst_n   (i_rst_n),
    .i_req_a   (mem_req_a),
    .i_req_b   (mem_req_b),
    .i_dmem_we (o_dmem_we),
    .i_wb_a    (o_wb_a),
    .i_wb_b    (o_wb_b)
);

`default_nettype wire

// File: source/lc4_superscalar.sv
`default_nettype none

module lc4_superscalar #(
    parameter lc4_pkg::word_t p_reset_pc = 16'h8200
) (
    input  wire                   gwe,
    input  wire                   i_rst_n,
    output lc4_pkg::word_t        o_pc,
    input  wire lc4_pkg::word_t   i_insn_a,
    input  wire lc4_pkg::word_t   i_insn_b,
    output lc4_pkg::word_t        o_dmem_addr,
    output logic                  o_dmem_we,
    output lc4_pkg::word_t        o_dmem_wdata,
    input  wire lc4_pkg::word_t   i_dmem_rdata,
    output lc4_pkg::wb_trace_t    o_wb_a,
    output lc4_pkg::wb_trace_t    o_wb_b
);

    lc4_pkg::lane_slot_t     x_slot_a;
    lc4_pkg::lane_slot_t     x_slot_b;
    lc4_pkg::reg_sel_t [1:0] rd_sel_a;
    lc4_pkg::reg_sel_t [1:0] rd_sel_b;
    lc4_pkg::word_t          rs_a;
    lc4_pkg::word_t          rt_a;
    lc4_pkg::word_t          rs_b;
    lc4_pkg::word_t          rt_b;
    lc4_pkg::fwd_t           x_load_a;
    lc4_pkg::fwd_t           x_load_b;
    lc4_pkg::fwd_t           m_fwd_a;
    lc4_pkg::fwd_t           m_fwd_b;
    lc4_pkg::fwd_t           w_fwd_a;
    lc4_pkg::fwd_t           w_fwd_b;
    lc4_pkg::mem_req_t       mem_req_a;
    lc4_pkg::mem_req_t       mem_req_b;
    lc4_pkg::word_t          store_data_a;
    lc4_pkg::word_t          store_data_b;
    lc4_pkg::word_t          load_word;

    lc4_issue_ctrl #(
        .p_reset_pc (p_reset_pc)
    ) u_issue (
        .gwe        (gwe),
        .i_rst_n    (i_rst_n),
        .i_insn_a   (i_insn_a),
        .i_insn_b   (i_insn_b),
        .i_x_load_a (x_load_a),
        .i_x_load_b (x_load_b),
        .o_pc       (o_pc),
        .o_rd_sel_a (rd_sel_a),
        .o_rd_sel_b (rd_sel_b),
        .o_x_slot_a (x_slot_a),
        .o_x_slot_b (x_slot_b),
        .o_stall_a  (),
        .o_stall_b  ()
    );

    // index 0 is rs, index 1 is rt
    lc4_regfile u_regfile (
        .gwe     (gwe),
        .i_rst_n (i_rst_n),
        .i_rs_a  (rd_sel_a[0]),
        .i_rt_a  (rd_sel_a[1]),
        .i_rs_b  (rd_sel_b[0]),
        .i_rt_b  (rd_sel_b[1]),
        .o_rs_a  (rs_a),
        .o_rt_a  (rt_a),
        .o_rs_b  (rs_b),
        .o_rt_b  (rt_b),
        .i_wr_a  (w_fwd_a),
        .i_wr_b  (w_fwd_b)
    );

    lc4_exec_lane u_lane_a (
        .gwe          (gwe),
        .i_rst_n      (i_rst_n),
        .i_x_slot     (x_slot_a),
        .i_rs_data    (rs_a),
        .i_rt_data    (rt_a),
        .i_m_a        (m_fwd_a),
        .i_m_b        (m_fwd_b),
        .i_w_a        (w_fwd_a),
        .i_w_b        (w_fwd_b),
        .i_store_data (store_data_a),
        .i_load_word  (load_word),
        .o_x_load     (x_load_a),
        .o_m_fwd      (m_fwd_a),
        .o_w_fwd      (w_fwd_a),
        .o_mem_req    (mem_req_a),
        .o_wb         (o_wb_a)
    );

    lc4_exec_lane u_lane_b (
        .gwe          (gwe),
        .i_rst_n      (i_rst_n),
        .i_x_slot     (x_slot_b),
        .i_rs_data    (rs_b),
        .i_rt_data    (rt_b),
        .i_m_a        (m_fwd_a),
        .i_m_b        (m_fwd_b),
        .i_w_a        (w_fwd_a),
        .i_w_b        (w_fwd_b),
        .i_store_data (store_data_b),
        .i_load_word  (load_word),
        .o_x_load     (x_load_b),
        .o_m_fwd      (m_fwd_b),
        .o_w_fwd      (w_fwd_b),
        .o_mem_req    (mem_req_b),
        .o_wb         (o_wb_b)
    );

    lc4_dmem_arbiter u_arbiter (
        .gwe            (gwe),
        .i_rst_n        (i_rst_n),
        .i_req_a        (mem_req_a),
        .i_req_b        (mem_req_b),
        .i_w_a          (w_fwd_a),
        .i_w_b          (w_fwd_b),
        .i_m_a          (m_fwd_a),
        .i_rdata        (i_dmem_rdata),
        .o_addr         (o_dmem_addr),
        .o_wdata        (o_dmem_wdata),
        .o_we           (o_dmem_we),
        .o_store_data_a (store_data_a),
        .o_store_data_b (store_data_b),
        .o_load_word    (load_word)
    );

endmodule

`default_nettype wire

// File: source/lc4_dmem_arbiter.sv
`default_nettype none

module lc4_dmem_arbiter (
    input  wire                     gwe,
    input  wire                     i_rst_n,
    input  wire lc4_pkg::mem_req_t  i_req_a,
    input  wire lc4_pkg::mem_req_t  i_req_b,
    input  wire lc4_pkg::fwd_t      i_w_a,
    input  wire lc4_pkg::fwd_t      i_w_b,
    input  wire lc4_pkg::fwd_t      i_m_a,
    input  wire lc4_pkg::word_t     i_rdata,
    output lc4_pkg::word_t          o_addr,
    output lc4_pkg::word_t          o_wdata,
    output logic                    o_we,
    output lc4_pkg::word_t          o_store_data_a,
    output lc4_pkg::word_t          o_store_data_b,
    output lc4_pkg::word_t          o_load_word
);

    logic grant_a;

    function automatic logic hit(lc4_pkg::fwd_t src, lc4_pkg::reg_sel_t rt);
        return src.we && src.rd == rt;
    endfunction

    always_comb begin
        grant_a = i_req_a.load || i_req_a.store;

        if (hit(i_w_b, i_req_a.rt)) begin
            o_store_data_a = i_w_b.value;
        end else if (hit(i_w_a, i_req_a.rt)) begin
            o_store_data_a = i_w_a.value;
        end else begin
            o_store_data_a = i_req_a.wdata;
        end

        // lane a in M is older than b and younger than anything in W
        if (hit(i_m_a, i_req_b.rt)) begin
            o_store_data_b = i_m_a.value;
        end else if (hit(i_w_b, i_req_b.rt)) begin
            o_store_data_b = i_w_b.value;
        end else if (hit(i_w_a, i_req_b.rt)) begin
            o_store_data_b = i_w_a.value;
        end else begin
            o_store_data_b = i_req_b.wdata;
        end

        o_addr  = grant_a ? i_req_a.addr  : i_req_b.addr;
        o_we    = grant_a ? i_req_a.store : i_req_b.store;
        o_wdata = grant_a ? o_store_data_a : o_store_data_b;
    end

    // at most one load per cycle, so one word serves both lanes in W
    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            o_load_word <= '0;
        end else begin
            o_load_word <= i_rdata;
        end
    end

endmodule

`default_nettype wire

// File: source/lc4_exec_lane.sv
`default_nettype none

module lc4_exec_lane (
    input  wire                       gwe,
    input  wire                       i_rst_n,
    input  wire lc4_pkg::lane_slot_t  i_x_slot,
    input  wire lc4_pkg::word_t       i_rs_data,
    input  wire lc4_pkg::word_t       i_rt_data,
    input  wire lc4_pkg::fwd_t        i_m_a,
    input  wire lc4_pkg::fwd_t        i_m_b,
    input  wire lc4_pkg::fwd_t        i_w_a,
    input  wire lc4_pkg::fwd_t        i_w_b,
    input  wire lc4_pkg::word_t       i_store_data,
    input  wire lc4_pkg::word_t       i_load_word,
    output lc4_pkg::fwd_t             o_x_load,
    output lc4_pkg::fwd_t             o_m_fwd,
    output lc4_pkg::fwd_t             o_w_fwd,
    output lc4_pkg::mem_req_t         o_mem_req,
    output lc4_pkg::wb_trace_t        o_wb
);

    lc4_pkg::lane_slot_t x_q;
    lc4_pkg::lane_slot_t m_q;
    lc4_pkg::lane_slot_t w_q;
    lc4_pkg::word_t      x_rs_q;
    lc4_pkg::word_t      x_rt_q;
    lc4_pkg::word_t      rs_val;
    lc4_pkg::word_t      rt_val;
    lc4_pkg::word_t      alu_res;
    lc4_pkg::word_t      m_alu_q;
    lc4_pkg::word_t      m_rt_q;
    lc4_pkg::word_t      w_val_q;
    lc4_pkg::word_t      w_data;

    // youngest writer first: M of b, M of a, W of b, W of a
    function automatic lc4_pkg::word_t bypass(lc4_pkg::reg_sel_t sel, lc4_pkg::word_t rf,
                                              lc4_pkg::fwd_t m_b, lc4_pkg::fwd_t m_a,
                                              lc4_pkg::fwd_t w_b, lc4_pkg::fwd_t w_a);
        if (m_b.we && m_b.rd == sel) return m_b.value;
        if (m_a.we && m_a.rd == sel) return m_a.value;
        if (w_b.we && w_b.rd == sel) return w_b.value;
        if (w_a.we && w_a.rd == sel) return w_a.value;
        return rf;
    endfunction

    always_comb begin
        rs_val = bypass(x_q.dec.rs, x_rs_q, i_m_b, i_m_a, i_w_b, i_w_a);
        rt_val = bypass(x_q.dec.rt, x_rt_q, i_m_b, i_m_a, i_w_b, i_w_a);
        case (x_q.dec.op)
            lc4_pkg::op_add:   alu_res = rs_val + rt_val;
            lc4_pkg::op_sub:   alu_res = rs_val - rt_val;
            lc4_pkg::op_and:   alu_res = rs_val & rt_val;
            lc4_pkg::op_addi:  alu_res = rs_val + {{11{x_q.insn[4]}}, x_q.insn[4:0]};
            lc4_pkg::op_const: alu_res = {{7{x_q.insn[8]}}, x_q.insn[8:0]};
            // memory ops use the ALU for base plus offset
            lc4_pkg::op_ldr,
            lc4_pkg::op_str:   alu_res = rs_val + {{10{x_q.insn[5]}}, x_q.insn[5:0]};
            default:           alu_res = '0;
        endcase
        w_data = w_q.dec.is_load ? i_load_word : w_val_q;
    end

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            x_q <= '0;
            m_q <= '0;
            w_q <= '0;
        end else begin
            x_q <= i_x_slot;
            m_q <= x_q;
            w_q <= m_q;
        end
    end

    always_ff @(posedge gwe) begin
        x_rs_q  <= i_rs_data;
        x_rt_q  <= i_rt_data;
        m_alu_q <= alu_res;
        m_rt_q  <= rt_val;
        // a store brings its final data into W for the trace
        w_val_q <= m_q.dec.is_store ? i_store_data : m_alu_q;
    end

    assign o_x_load = '{we: x_q.valid && x_q.dec.is_load, rd: x_q.dec.rd, value: alu_res};
    assign o_m_fwd  = '{we: m_q.valid && m_q.dec.rd_we, rd: m_q.dec.rd, value: m_alu_q};
    assign o_w_fwd  = '{we: w_q.valid && w_q.dec.rd_we, rd: w_q.dec.rd, value: w_data};

    assign o_mem_req = '{load:  m_q.valid && m_q.dec.is_load,
                         store: m_q.valid && m_q.dec.is_store,
                         rt:    m_q.dec.rt,
                         addr:  m_alu_q,
                         wdata: m_rt_q};

    assign o_wb = '{valid: w_q.valid,
                    pc:    w_q.pc,
                    insn:  w_q.insn,
                    we:    w_q.valid && w_q.dec.rd_we,
                    wsel:  w_q.dec.rd,
                    wdata: w_data};

endmodule

`default_nettype wire

// File: source/lc4_issue_ctrl.sv
`default_nettype none

module lc4_issue_ctrl #(
    parameter lc4_pkg::word_t p_reset_pc = 16'h8200
) (
    input  wire                     gwe,
    input  wire                     i_rst_n,
    input  wire lc4_pkg::word_t     i_insn_a,
    input  wire lc4_pkg::word_t     i_insn_b,
    input  wire lc4_pkg::fwd_t      i_x_load_a,
    input  wire lc4_pkg::fwd_t      i_x_load_b,
    output lc4_pkg::word_t          o_pc,
    output lc4_pkg::reg_sel_t [1:0] o_rd_sel_a,
    output lc4_pkg::reg_sel_t [1:0] o_rd_sel_b,
    output lc4_pkg::lane_slot_t     o_x_slot_a,
    output lc4_pkg::lane_slot_t     o_x_slot_b,
    output lc4_pkg::stall_e         o_stall_a,
    output lc4_pkg::stall_e         o_stall_b
);

    lc4_pkg::word_t    pc_q;
    logic              d_valid_a;
    logic              d_valid_b;
    lc4_pkg::word_t    d_pc_a;
    lc4_pkg::word_t    d_pc_b;
    lc4_pkg::word_t    d_insn_a;
    lc4_pkg::word_t    d_insn_b;
    lc4_pkg::decoded_t dec_a;
    lc4_pkg::decoded_t dec_b;
    logic              luse_a;
    logic              luse_b;
    logic              b_needs_a;
    logic              mem_pair;
    logic              split;

    // store data is exempt, it is picked up again in M
    function automatic logic reads_reg(lc4_pkg::decoded_t dec, logic we, lc4_pkg::reg_sel_t rd);
        return we && ((dec.rs_re && dec.rs == rd) ||
                      (dec.rt_re && !dec.is_store && dec.rt == rd));
    endfunction

    lc4_decoder u_dec_a (
        .i_insn (d_insn_a),
        .o_dec  (dec_a)
    );

    lc4_decoder u_dec_b (
        .i_insn (d_insn_b),
        .o_dec  (dec_b)
    );

    always_comb begin
        luse_a    = d_valid_a && (reads_reg(dec_a, i_x_load_a.we, i_x_load_a.rd) ||
                                  reads_reg(dec_a, i_x_load_b.we, i_x_load_b.rd));
        luse_b    = d_valid_b && (reads_reg(dec_b, i_x_load_a.we, i_x_load_a.rd) ||
                                  reads_reg(dec_b, i_x_load_b.we, i_x_load_b.rd));
        b_needs_a = reads_reg(dec_b, dec_a.rd_we, dec_a.rd);
        // one data port, so two memory ops go one at a time
        mem_pair  = (dec_a.is_load || dec_a.is_store) && (dec_b.is_load || dec_b.is_store);
        split     = !luse_a && d_valid_b && (b_needs_a || mem_pair || luse_b);
    end

    assign o_pc       = pc_q;
    assign o_rd_sel_a = {dec_a.rt, dec_a.rs};
    assign o_rd_sel_b = {dec_b.rt, dec_b.rs};

    assign o_x_slot_a = (d_valid_a && !luse_a) ?
        lc4_pkg::lane_slot_t'{valid: 1'b1, pc: d_pc_a, insn: d_insn_a, dec: dec_a} : '0;
    assign o_x_slot_b = (d_valid_b && !luse_a && !split) ?
        lc4_pkg::lane_slot_t'{valid: 1'b1, pc: d_pc_b, insn: d_insn_b, dec: dec_b} : '0;

    assign o_stall_a = luse_a ? lc4_pkg::stall_load_use : lc4_pkg::stall_none;
    assign o_stall_b = luse_a ? lc4_pkg::stall_load_use :
                       split  ? lc4_pkg::stall_split    : lc4_pkg::stall_none;

    // a load-use stall on a holds the pc and both decode slots
    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            pc_q      <= p_reset_pc;
            d_valid_a <= 1'b0;
            d_valid_b <= 1'b0;
        end else if (!luse_a) begin
            if (split) begin
                // b slides into lane a, fetch moves by one word
                d_valid_a <= d_valid_b;
                d_pc_a    <= d_pc_b;
                d_insn_a  <= d_insn_b;
                d_valid_b <= 1'b1;
                d_pc_b    <= pc_q;
                d_insn_b  <= i_insn_a;
                pc_q      <= pc_q + 16'd1;
            end else begin
                d_valid_a <= 1'b1;
                d_pc_a    <= pc_q;
                d_insn_a  <= i_insn_a;
                d_valid_b <= 1'b1;
                d_pc_b    <= pc_q + 16'd1;
                d_insn_b  <= i_insn_b;
                pc_q      <= pc_q + 16'd2;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/lc4_regfile.sv
`default_nettype none

module lc4_regfile (
    input  wire                     gwe,
    input  wire                     i_rst_n,
    input  wire lc4_pkg::reg_sel_t  i_rs_a,
    input  wire lc4_pkg::reg_sel_t  i_rt_a,
    input  wire lc4_pkg::reg_sel_t  i_rs_b,
    input  wire lc4_pkg::reg_sel_t  i_rt_b,
    output lc4_pkg::word_t          o_rs_a,
    output lc4_pkg::word_t          o_rt_a,
    output lc4_pkg::word_t          o_rs_b,
    output lc4_pkg::word_t          o_rt_b,
    input  wire lc4_pkg::fwd_t      i_wr_a,
    input  wire lc4_pkg::fwd_t      i_wr_b
);

    lc4_pkg::word_t regs [8];

    // lane b is younger, so it is checked first
    function automatic lc4_pkg::word_t read_port(lc4_pkg::reg_sel_t sel,
                                                 lc4_pkg::word_t stored,
                                                 lc4_pkg::fwd_t wr_a,
                                                 lc4_pkg::fwd_t wr_b);
        if (wr_b.we && wr_b.rd == sel) return wr_b.value;
        if (wr_a.we && wr_a.rd == sel) return wr_a.value;
        return stored;
    endfunction

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (i_wr_a.we) regs[i_wr_a.rd] <= i_wr_a.value;
            // same target in both lanes leaves lane b's value
            if (i_wr_b.we) regs[i_wr_b.rd] <= i_wr_b.value;
        end
    end

    assign o_rs_a = read_port(i_rs_a, regs[i_rs_a], i_wr_a, i_wr_b);
    assign o_rt_a = read_port(i_rt_a, regs[i_rt_a], i_wr_a, i_wr_b);
    assign o_rs_b = read_port(i_rs_b, regs[i_rs_b], i_wr_a, i_wr_b);
    assign o_rt_b = read_port(i_rt_b, regs[i_rt_b], i_wr_a, i_wr_b);

endmodule

`default_nettype wire

// File: source/lc4_decoder.sv
`default_nettype none

module lc4_decoder (
    input  wire lc4_pkg::word_t i_insn,
    output lc4_pkg::decoded_t   o_dec
);

    lc4_pkg::op_e op;

    always_comb begin
        op = lc4_pkg::op_nop;
        case (i_insn[15:12])
            lc4_pkg::opc_arith: begin
                // immediate form is flagged by bit 5
                if (i_insn[5]) begin
                    op = lc4_pkg::op_addi;
                end else if (i_insn[5:3] == lc4_pkg::fn_add) begin
                    op = lc4_pkg::op_add;
                end else if (i_insn[5:3] == lc4_pkg::fn_sub) begin
                    op = lc4_pkg::op_sub;
                end
            end
            lc4_pkg::opc_logic: begin
                if (i_insn[5:3] == lc4_pkg::fn_and) begin
                    op = lc4_pkg::op_and;
                end
            end
            lc4_pkg::opc_ldr:   op = lc4_pkg::op_ldr;
            lc4_pkg::opc_str:   op = lc4_pkg::op_str;
            lc4_pkg::opc_const: op = lc4_pkg::op_const;
            default:            op = lc4_pkg::op_nop;
        endcase
    end

    always_comb begin
        o_dec.op       = op;
        o_dec.rs       = i_insn[8:6];
        // a store keeps its data register where the others keep rd
        o_dec.rt       = (op == lc4_pkg::op_str) ? i_insn[11:9] : i_insn[2:0];
        o_dec.rd       = i_insn[11:9];
        o_dec.rs_re    = op inside {lc4_pkg::op_add, lc4_pkg::op_sub, lc4_pkg::op_and,
                                    lc4_pkg::op_addi, lc4_pkg::op_ldr, lc4_pkg::op_str};
        o_dec.rt_re    = op inside {lc4_pkg::op_add, lc4_pkg::op_sub, lc4_pkg::op_and,
                                    lc4_pkg::op_str};
        o_dec.rd_we    = !(op inside {lc4_pkg::op_nop, lc4_pkg::op_str});
        o_dec.is_load  = (op == lc4_pkg::op_ldr);
        o_dec.is_store = (op == lc4_pkg::op_str);
    end

endmodule

`default_nettype wire

// File: source/lc4_pkg.sv
`default_nettype none

package lc4_pkg;

    // data, address and instruction words share one width
    typedef logic [15:0] word_t;
    typedef logic [2:0]  reg_sel_t;

    // primary opcodes in insn[15:12]
    localparam logic [3:0] opc_arith = 4'b0001;
    localparam logic [3:0] opc_logic = 4'b0101;
    localparam logic [3:0] opc_ldr   = 4'b0110;
    localparam logic [3:0] opc_str   = 4'b0111;
    localparam logic [3:0] opc_const = 4'b1001;

    // sub-opcodes in insn[5:3] for arith and logic
    localparam logic [2:0] fn_add = 3'b000;
    localparam logic [2:0] fn_sub = 3'b010;
    localparam logic [2:0] fn_and = 3'b000;

    typedef enum logic [2:0] {
        op_nop, op_add, op_sub, op_and,
        op_addi, op_const, op_ldr, op_str
    } op_e;

    typedef enum logic [1:0] {
        stall_none, stall_load_use, stall_split
    } stall_e;

    typedef struct packed {
        op_e      op;
        reg_sel_t rs;
        reg_sel_t rt;
        reg_sel_t rd;
        logic     rs_re;
        logic     rt_re;
        logic     rd_we;
        logic     is_load;
        logic     is_store;
    } decoded_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    insn;
        decoded_t dec;
    } lane_slot_t;

    // a register writer seen by the bypass network
    typedef struct packed {
        logic     we;
        reg_sel_t rd;
        word_t    value;
    } fwd_t;

    // rt lets the arbiter match store data against later writers
    typedef struct packed {
        logic     load;
        logic     store;
        reg_sel_t rt;
        word_t    addr;
        word_t    wdata;
    } mem_req_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    insn;
        logic     we;
        reg_sel_t wsel;
        word_t    wdata;
    } wb_trace_t;

endpackage

`default_nettype wire
